// ==== hdl/stq_cfg_pkg.sv ====
`default_nettype none

package stq_cfg_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Queue geometry.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int STQ_ENTRIES = 64;  // Store queue depth.
  localparam int STQ_DATA_W  = 32;
  localparam int CHK_PORTS   = 8;   // Load check ports.

  // Ports 0 to 5 may fall back to these two ports on a miss.
  localparam int FWD_NEAR_PORT = 6;  // Chosen by pre0 alone.
  localparam int FWD_FAR_PORT  = 7;  // Chosen by pre1.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Vector types.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // One store data word.
  typedef logic [STQ_DATA_W-1:0] stq_data_t;

  // One bit per queue entry, used for write, free and check selects.
  typedef logic [STQ_ENTRIES-1:0] entry_mask_t;

  // One bit per check port.
  typedef logic [CHK_PORTS-1:0] port_vec_t;

endpackage

`default_nettype wire

// ==== hdl/stq_if_pkg.sv ====
`default_nettype none

package stq_if_pkg;

  import stq_cfg_pkg::*;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Traffic into the store queue data side.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // A store writing its data into the entries named by en.
  typedef struct packed {
    entry_mask_t en;
    stq_data_t   data;
  } stq_write_t;

  // Commit retiring entries.
  typedef struct packed {
    entry_mask_t en;
  } stq_free_t;

  // A load checking one entry. The mask is one-hot or all zero.
  // On a miss pre1 selects the far port, pre0 alone the near port.
  // The two fallback ports themselves ignore both bits.
  typedef struct packed {
    entry_mask_t en;
    logic        pre0;
    logic        pre1;
  } stq_check_t;

endpackage

`default_nettype wire

// ==== hdl/stq_data_array.sv ====
`timescale 1ns/1ns
`default_nettype none

module stq_data_array (
  input  wire                           clk,
  input  wire stq_if_pkg::stq_write_t   wr0,
  input  wire stq_if_pkg::stq_write_t   wr1,
  input  wire stq_cfg_pkg::entry_mask_t chk_en   [stq_cfg_pkg::CHK_PORTS],
  output stq_cfg_pkg::stq_data_t        raw_data [stq_cfg_pkg::CHK_PORTS]
);

  import stq_cfg_pkg::*;

  localparam int BANKS = 8;
  localparam int ROWS  = STQ_ENTRIES / BANKS;  // Entries per bank.

  stq_data_t entry_data [STQ_ENTRIES];
  stq_data_t bank_data  [CHK_PORTS][BANKS];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Entry storage.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Port 1 is assigned last, so it wins when both ports name one entry.
  always_ff @(posedge clk) begin
    for (int e = 0; e < STQ_ENTRIES; e++) begin
      if (wr0.en[e]) begin
        entry_data[e] <= wr0.data;
      end
      if (wr1.en[e]) begin
        entry_data[e] <= wr1.data;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Check reads.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Each bank ORs its eight rows, each gated by the row's mask bit.
  always_comb begin
    for (int p = 0; p < CHK_PORTS; p++) begin
      for (int b = 0; b < BANKS; b++) begin
        bank_data[p][b] = '0;
        for (int r = 0; r < ROWS; r++) begin
          bank_data[p][b] |= entry_data[b*ROWS + r] &
                             {STQ_DATA_W{chk_en[p][b*ROWS + r]}};
        end
      end
    end
  end

  // The banks are merged with a second OR level. An empty mask reads zero.
  always_comb begin
    for (int p = 0; p < CHK_PORTS; p++) begin
      raw_data[p] = '0;
      for (int b = 0; b < BANKS; b++) begin
        raw_data[p] |= bank_data[p][b];
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/stq_valid_track.sv ====
`timescale 1ns/1ns
`default_nettype none

module stq_valid_track (
  input  wire                           clk,
  input  wire                           rst,
  input  wire stq_cfg_pkg::entry_mask_t wr0_en,
  input  wire stq_cfg_pkg::entry_mask_t wr1_en,
  input  wire stq_if_pkg::stq_free_t    free,
  input  wire stq_cfg_pkg::entry_mask_t chk_en [stq_cfg_pkg::CHK_PORTS],
  output stq_cfg_pkg::port_vec_t        chk_hit
);

  import stq_cfg_pkg::*;

  entry_mask_t valid;
  entry_mask_t set_mask;

  assign set_mask = wr0_en | wr1_en;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Valid bits.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // The free is applied first and the writes are ORed in after it, so a
  // write and a free of the same entry leave that entry valid.
  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= '0;
    end else begin
      valid <= (valid & ~free.en) | set_mask;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Hit per check port.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    for (int p = 0; p < CHK_PORTS; p++) begin
      chk_hit[p] = |(chk_en[p] & valid);  // Only registered valid bits count.
    end
  end

endmodule

`default_nettype wire

// ==== hdl/stq_forward_merge.sv ====
`timescale 1ns/1ns
`default_nettype none

module stq_forward_merge (
  input  wire stq_cfg_pkg::stq_data_t  raw_data [stq_cfg_pkg::CHK_PORTS],
  input  wire stq_cfg_pkg::port_vec_t  chk_hit,
  input  wire stq_if_pkg::stq_check_t  chk      [stq_cfg_pkg::CHK_PORTS],
  output stq_cfg_pkg::stq_data_t       chk_data [stq_cfg_pkg::CHK_PORTS]
);

  import stq_cfg_pkg::*;

  stq_data_t near_data;
  stq_data_t far_data;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Fallback ports.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // These two ports have nowhere else to look, so a miss gives zero.
  assign near_data = chk_hit[FWD_NEAR_PORT] ? raw_data[FWD_NEAR_PORT] : '0;
  assign far_data  = chk_hit[FWD_FAR_PORT]  ? raw_data[FWD_FAR_PORT]  : '0;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Final data per port.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // A hit on the port's own entry comes first. On a miss pre1 takes the far
  // port's final data, pre0 alone the near port's.
  always_comb begin
    for (int p = 0; p < CHK_PORTS; p++) begin
      if (p == FWD_NEAR_PORT) begin
        chk_data[p] = near_data;
      end else if (p == FWD_FAR_PORT) begin
        chk_data[p] = far_data;
      end else if (chk_hit[p]) begin
        chk_data[p] = raw_data[p];
      end else if (chk[p].pre1) begin
        chk_data[p] = far_data;
      end else if (chk[p].pre0) begin
        chk_data[p] = near_data;
      end else begin
        chk_data[p] = '0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/stq_forward_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module stq_forward_top (
  input  wire                          clk,
  input  wire                          rst,
  input  wire stq_if_pkg::stq_write_t  wr0,
  input  wire stq_if_pkg::stq_write_t  wr1,
  input  wire stq_if_pkg::stq_free_t   free,
  input  wire stq_if_pkg::stq_check_t  chk      [stq_cfg_pkg::CHK_PORTS],
  output stq_cfg_pkg::stq_data_t       chk_data [stq_cfg_pkg::CHK_PORTS],
  output stq_cfg_pkg::port_vec_t       chk_hit
);

  import stq_cfg_pkg::*;

  entry_mask_t chk_en   [CHK_PORTS];  // Entry selects split off the checks.
  stq_data_t   raw_data [CHK_PORTS];

  for (genvar p = 0; p < CHK_PORTS; p++) begin : g_chk_en
    assign chk_en[p] = chk[p].en;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Data and valid paths run side by side and meet in the merge.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  stq_data_array u_data (
    .clk      (clk),
    .wr0      (wr0),
    .wr1      (wr1),
    .chk_en   (chk_en),
    .raw_data (raw_data)
  );

  stq_valid_track u_valid (
    .clk     (clk),
    .rst     (rst),
    .wr0_en  (wr0.en),
    .wr1_en  (wr1.en),
    .free    (free),
    .chk_en  (chk_en),
    .chk_hit (chk_hit)
  );

  stq_forward_merge u_merge (
    .raw_data (raw_data),
    .chk_hit  (chk_hit),
    .chk      (chk),
    .chk_data (chk_data)
  );

endmodule

`default_nettype wire

// ==== verification/stq_forward_properties.sv ====
`timescale 1ns/1ns
`default_nettype none

module stq_forward_properties (
  input wire                          clk,
  input wire                          rst,
  input wire stq_if_pkg::stq_check_t  chk      [stq_cfg_pkg::CHK_PORTS],
  input wire stq_cfg_pkg::stq_data_t  chk_data [stq_cfg_pkg::CHK_PORTS],
  input wire stq_cfg_pkg::port_vec_t  chk_hit
);

  import stq_cfg_pkg::*;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reset.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Reset clears every valid bit, so nothing can hit right after it.
  hit_low_after_reset: assert property (@(posedge clk) rst |=> chk_hit == '0)
    else $error("chk_hit is not zero in the cycle after reset");

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Zero results.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  for (genvar p = 0; p < CHK_PORTS; p++) begin : g_port
    idle_port_zero: assert property (@(posedge clk) disable iff (rst)
      (chk[p].en == '0 && !chk[p].pre0 && !chk[p].pre1) |-> chk_data[p] == '0)
      else $error("port %0d has no mask and no prefer bit but its data is not zero", p);
  end

  near_miss_zero: assert property (@(posedge clk) disable iff (rst)
    !chk_hit[FWD_NEAR_PORT] |-> chk_data[FWD_NEAR_PORT] == '0)
    else $error("near fallback port returns data without a hit");

  far_miss_zero: assert property (@(posedge clk) disable iff (rst)
    !chk_hit[FWD_FAR_PORT] |-> chk_data[FWD_FAR_PORT] == '0)
    else $error("far fallback port returns data without a hit");

endmodule

bind stq_forward_top stq_forward_properties u_props (
  .clk      (clk),
  .rst      (rst),
  .chk      (chk),
  .chk_data (chk_data),
  .chk_hit  (chk_hit)
);

`default_nettype wire

// ==== verification/stq_forward_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module stq_forward_tb;

  import stq_cfg_pkg::*;
  import stq_if_pkg::*;

  localparam int  CLK_PERIOD      = 10;
  localparam int  RESET_CYCLES    = 5;
  localparam int  DIRECTED_CYCLES = 40;    // Upper bound for the directed part.
  localparam int  RAND_CYCLES     = 2000;
  localparam time TIMEOUT = (RESET_CYCLES + DIRECTED_CYCLES + RAND_CYCLES) * CLK_PERIOD + 500;

  // Expected outputs of all check ports in one cycle.
  typedef struct packed {
    stq_data_t [CHK_PORTS-1:0] data;
    port_vec_t                 hit;
  } expect_t;

  logic        clk = 1'b0;
  logic        rst;
  stq_write_t  wr0;
  stq_write_t  wr1;
  stq_free_t   free;
  stq_check_t  chk      [CHK_PORTS];
  stq_data_t   chk_data [CHK_PORTS];
  port_vec_t   chk_hit;

  stq_data_t   model_data [STQ_ENTRIES];
  entry_mask_t model_valid;
  int          seed;

  always #(CLK_PERIOD / 2) clk = ~clk;

  stq_forward_top DUT (
    .clk      (clk),
    .rst      (rst),
    .wr0      (wr0),
    .wr1      (wr1),
    .free     (free),
    .chk      (chk),
    .chk_data (chk_data),
    .chk_hit  (chk_hit)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reference model.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always @(posedge clk) begin
    for (int e = 0; e < STQ_ENTRIES; e++) begin
      if (wr1.en[e]) begin
        model_data[e] = wr1.data;  // Port 1 beats port 0.
      end else if (wr0.en[e]) begin
        model_data[e] = wr0.data;
      end
      if (rst) begin
        model_valid[e] = 1'b0;
      end else if (wr0.en[e] || wr1.en[e]) begin
        model_valid[e] = 1'b1;     // A write outranks a free.
      end else if (free.en[e]) begin
        model_valid[e] = 1'b0;
      end
    end
  end

  function automatic expect_t reference_result();
    expect_t   res;
    stq_data_t own [CHK_PORTS];
    res = '0;
    for (int p = 0; p < CHK_PORTS; p++) begin
      own[p] = '0;
      for (int e = 0; e < STQ_ENTRIES; e++) begin
        if (chk[p].en[e] && model_valid[e]) begin
          res.hit[p] = 1'b1;
          own[p]     = model_data[e];
        end
      end
    end
    // A port without a hit has own data zero, which is also what the two
    // fallback ports pass on after a miss.
    for (int p = 0; p < CHK_PORTS; p++) begin
      if (res.hit[p] || p == FWD_NEAR_PORT || p == FWD_FAR_PORT) begin
        res.data[p] = own[p];
      end else if (chk[p].pre1) begin
        res.data[p] = own[FWD_FAR_PORT];
      end else if (chk[p].pre0) begin
        res.data[p] = own[FWD_NEAR_PORT];
      end else begin
        res.data[p] = '0;
      end
    end
    return res;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Checking.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] want);
    if (got !== want) begin
      $display("FAIL at %0t ns: %s is %h, expected %h", $time, what, got, want);
      $display("TEST FAIL");
      $fatal(1, "Stopping at the first mismatch.");
    end
  endtask

  task automatic expect_port(input int p, input logic hit, input stq_data_t data);
    check_value($sformatf("port %0d hit", p), 32'(chk_hit[p]), 32'(hit));
    check_value($sformatf("port %0d data", p), chk_data[p], data);
  endtask

  // Compares all ports one nanosecond before each rising edge.
  initial begin
    expect_t want;
    forever begin
      @(negedge clk);
      #(CLK_PERIOD / 2 - 1);
      if (!rst) begin
        want = reference_result();
        check_value("chk_hit", 32'(chk_hit), 32'(want.hit));
        for (int p = 0; p < CHK_PORTS; p++) begin
          check_value($sformatf("chk_data[%0d]", p), chk_data[p], want.data[p]);
        end
      end
    end
  end

  initial begin
    #(TIMEOUT);
    $display("Watchdog expired: the test did not finish within %0t ns.", TIMEOUT);
    $display("TEST FAIL");
    $fatal(1, "Watchdog timeout.");
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic entry_mask_t onehot(input int e);
    return entry_mask_t'(1) << e;
  endfunction

  task automatic clear_inputs();
    wr0  = '0;
    wr1  = '0;
    free = '0;
    for (int p = 0; p < CHK_PORTS; p++) begin
      chk[p] = '0;
    end
  endtask

  // Moves to the next falling edge with all inputs idle.
  task automatic step();
    @(negedge clk);
    clear_inputs();
  endtask

  task automatic drive_random();
    int r;
    r = $random(seed);
    if (r[0]) wr0.en = onehot(int'(r[7:2]));
    if (r[8]) wr1.en = onehot(int'(r[15:10]));
    if (r[17:16] != 2'b00) free.en = onehot(int'(r[23:18]));
    wr0.data = $random(seed);
    wr1.data = $random(seed);
    for (int p = 0; p < CHK_PORTS; p++) begin
      r = $random(seed);
      chk[p].en   = (r[1:0] != 2'b00) ? onehot(int'(r[7:2])) : '0;
      chk[p].pre0 = r[8];
      chk[p].pre1 = r[9];
    end
  endtask

  initial begin
    seed = 32'hf8fd_ff26;
    rst  = 1'b1;
    clear_inputs();
    // Writes during reset fill the data array but leave every entry invalid.
    wr0.en   = onehot(5);
    wr0.data = 32'h5555_0005;
    for (int p = 0; p < CHK_PORTS; p++) begin
      chk[p].en = onehot(5);
    end
    repeat (RESET_CYCLES) @(negedge clk);
    rst = 1'b0;
    wr0 = '0;  // The checks stay on entry 5 through the first cycle after reset.

    // Nothing is valid yet, so every entry misses on every port.
    for (int e = 0; e < STQ_ENTRIES; e += CHK_PORTS) begin
      step();
      for (int p = 0; p < CHK_PORTS; p++) begin
        chk[p].en   = onehot(e + p);
        chk[p].pre0 = p[0];
        chk[p].pre1 = p[1];
      end
      #2;
      for (int p = 0; p < CHK_PORTS; p++) expect_port(p, 1'b0, '0);
    end

    step();
    wr0.en   = onehot(13);
    wr0.data = 32'hcafe_0013;
    step();
    for (int p = 0; p < CHK_PORTS; p++) chk[p].en = onehot(13);
    #2;
    for (int p = 0; p < CHK_PORTS; p++) expect_port(p, 1'b1, 32'hcafe_0013);

    step();
    wr0.en   = onehot(20);
    wr0.data = 32'h1111_0020;
    wr1.en   = onehot(20);
    wr1.data = 32'h2222_0020;
    step();
    chk[0].en = onehot(20);
    #2;
    expect_port(0, 1'b1, 32'h2222_0020);

    // The free takes effect at the edge, not in its own cycle.
    step();
    free.en   = onehot(13);
    chk[1].en = onehot(13);
    #2;
    expect_port(1, 1'b1, 32'hcafe_0013);
    step();
    chk[1].en = onehot(13);
    #2;
    expect_port(1, 1'b0, '0);
    step();
    wr0.en   = onehot(21);
    wr0.data = 32'h3333_0021;
    step();
    wr1.en   = onehot(21);
    wr1.data = 32'h4444_0021;
    free.en  = onehot(21);
    step();
    chk[2].en = onehot(21);
    #2;
    expect_port(2, 1'b1, 32'h4444_0021);

    step();
    wr0.en   = onehot(30);
    wr0.data = 32'h6666_0030;
    wr1.en   = onehot(31);
    wr1.data = 32'h7777_0031;
    step();
    chk[6].en = onehot(30);
    chk[6].pre1 = 1'b1;  // Ignored on a fallback port.
    chk[7].en = onehot(31);
    chk[0] = '{en: onehot(13), pre0: 1'b1, pre1: 1'b1};
    chk[1] = '{en: onehot(13), pre0: 1'b1, pre1: 1'b0};
    chk[2] = '{en: onehot(13), pre0: 1'b0, pre1: 1'b0};
    chk[3] = '{en: onehot(40), pre0: 1'b0, pre1: 1'b1};
    chk[4] = '{en: '0, pre0: 1'b1, pre1: 1'b0};
    chk[5] = '{en: onehot(20), pre0: 1'b0, pre1: 1'b1};
    #2;
    expect_port(0, 1'b0, 32'h7777_0031);
    expect_port(1, 1'b0, 32'h6666_0030);
    expect_port(2, 1'b0, '0);
    expect_port(3, 1'b0, 32'h7777_0031);
    expect_port(4, 1'b0, 32'h6666_0030);
    expect_port(5, 1'b1, 32'h2222_0020);
    expect_port(6, 1'b1, 32'h6666_0030);
    expect_port(7, 1'b1, 32'h7777_0031);
    step();
    chk[7].en = onehot(13);  // Far port misses and passes on zero.
    chk[6].en = onehot(30);
    chk[0] = '{en: onehot(13), pre0: 1'b1, pre1: 1'b1};
    #2;
    expect_port(0, 1'b0, '0);
    expect_port(7, 1'b0, '0);

    for (int c = 0; c < RAND_CYCLES; c++) begin
      step();
      drive_random();
    end
    step();
    step();

    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
hdl/stq_cfg_pkg.sv
hdl/stq_if_pkg.sv
hdl/stq_data_array.sv
hdl/stq_valid_track.sv
hdl/stq_forward_merge.sv
hdl/stq_forward_top.sv
verification/stq_forward_properties.sv
verification/stq_forward_tb.sv

// ==== Makefile ====
TOP := stq_forward_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f all.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TEST PASS"

clean:
	rm -rf obj_dir
